/* run.sh */
#!/usr/bin/env bash
# build the srcCpu testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module srcCpuTb \
    -f srcCpu.f -o srcCpuSim || exit 1

simOutput="$(./obj_dir/srcCpuSim)"
echo "$simOutput"
echo "$simOutput" | grep -qF "Verification passed" && echo "run.sh: PASS" \
    || { echo "run.sh: FAIL"; exit 1; }

/* srcCpu.f */
+incdir+verilog
verilog/srcCpuPkg.sv
verilog/mainMemory.sv
verilog/registerFile.sv
verilog/alu.sv
verilog/datapath.sv
verilog/controlUnit.sv
verilog/srcCpu.sv
verif/clockGen.sv
verif/srcCpuTb.sv

/* verif/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
    parameter int halfPeriodNs = 10, // 20 ns period
    parameter int resetCycles  = 2
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(halfPeriodNs) clk = ~clk;
    end

    initial begin
        arstN = 1'b0;                   // reset from time zero
        repeat (resetCycles) @(posedge clk);
        #2 arstN = 1'b1;                // release off the edge
    end

endmodule

`default_nettype wire

/* verif/srcCpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "srcCpu_config.svh"

module srcCpuTb import srcCpuPkg::*; ();

    // opcode numbers of the instruction set
    localparam logic [4:0] codeLd   = 5'd0;
    localparam logic [4:0] codeLdi  = 5'd1;
    localparam logic [4:0] codeSt   = 5'd2;
    localparam logic [4:0] codeAdd  = 5'd3;
    localparam logic [4:0] codeSub  = 5'd4;
    localparam logic [4:0] codeAnd  = 5'd5;
    localparam logic [4:0] codeOr   = 5'd6;
    localparam logic [4:0] codeAddi = 5'd12;
    localparam logic [4:0] codeAndi = 5'd13;
    localparam logic [4:0] codeOri  = 5'd14;
    localparam logic [4:0] codeBr   = 5'd19;
    localparam logic [4:0] codeJr   = 5'd20;
    localparam logic [4:0] codeJal  = 5'd21;
    localparam logic [4:0] codeIn   = 5'd22;
    localparam logic [4:0] codeOut  = 5'd23;
    localparam logic [4:0] codeNop  = 5'd26;
    localparam logic [4:0] codeHalt = 5'd27;

    localparam int totalInstr = 150;   // program words of all tests
    localparam int cycleNs    = 20;
    localparam int marginNs   = 20000; // host loads and readbacks
    localparam int watchdogNs = totalInstr * 4 * cycleNs + marginNs;

    logic               clk, arstN, run, outValid, halted;
    memReqT             hostReq;
    logic [`WORD_W-1:0] hostRdata, inPort, outPort;

    logic [31:0] progWords[$];   // program image from address 0
    logic [31:0] expectedOut[$];
    logic [31:0] seenOut[$];     // every outValid pulse of the run
    int          outBase;        // first seenOut entry of this run
    int          errorCount, errorsAtStart, testsPassed, testsFailed;

    clockGen #(.halfPeriodNs(cycleNs / 2), .resetCycles(2)) u_clockGen (
        .clk   (clk),
        .arstN (arstN)
    );

    srcCpu u_srcCpu (
        .clk       (clk),
        .arstN     (arstN),
        .run       (run),
        .hostReq   (hostReq),
        .hostRdata (hostRdata),
        .inPort    (inPort),
        .outPort   (outPort),
        .outValid  (outValid),
        .halted    (halted)
    );

    always @(negedge clk) begin
        if (outValid) begin
            seenOut.push_back(outPort); // sampled mid-cycle once settled
        end
    end

    function automatic logic [31:0] signExtend19(input logic [18:0] c);
        return {{13{c[18]}}, c};
    endfunction

    function automatic logic [31:0] encodeReg(input logic [4:0] op, input logic [3:0] ra,
                                              input logic [3:0] rb, input logic [3:0] rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    function automatic logic [31:0] encodeImm(input logic [4:0] op, input logic [3:0] ra,
                                              input logic [3:0] rb, input logic [18:0] c2);
        return {op, ra, rb, c2};
    endfunction

    function automatic logic [31:0] encodeOut(input logic [3:0] ra);
        return encodeImm(codeOut, ra, 4'd0, 19'd0);
    endfunction

    // c2 plus base cut to the memory address width
    function automatic logic [8:0] effectiveAddress(input logic [31:0] base,
                                                    input logic [18:0] c2);
        logic [31:0] sum;
        sum = base + signExtend19(c2);
        return sum[8:0];
    endfunction

    function automatic logic branchTaken(input logic [31:0] value, input logic [1:0] cond);
        case (cond)
            2'd0:    return (value == 32'd0);
            2'd1:    return (value != 32'd0);
            2'd2:    return !value[31]; // sign clear
            default: return value[31];
        endcase
    endfunction

    task automatic waitDriveSlot();
        @(posedge clk);
        #2; // inputs change off the edge
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED: %s expected 0x%08h actual 0x%08h", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic writeWord(input logic [8:0] addr, input logic [31:0] data);
        waitDriveSlot();
        hostReq = '{read: 1'b0, write: 1'b1, addr: addr, wdata: data};
    endtask

    task automatic releaseHost();
        waitDriveSlot();
        hostReq = '0;
    endtask

    task automatic readWord(input logic [8:0] addr, output logic [31:0] data);
        waitDriveSlot();
        hostReq = '{read: 1'b1, write: 1'b0, addr: addr, wdata: 32'h0};
        waitDriveSlot();
        data    = hostRdata; // registered one clock later
        hostReq = '0;
    endtask

    task automatic loadProgram();
        foreach (progWords[i]) begin
            writeWord(9'(i), progWords[i]);
        end
        releaseHost();
    endtask

    task automatic runUntilHalt(input string testName);
        int cycles;
        int limit;
        limit   = progWords.size() * 4 + 10; // 4 cycles worst case per word
        cycles  = 0;
        outBase = seenOut.size();
        waitDriveSlot();
        run = 1'b1;
        @(negedge clk);
        while (!halted && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!halted) begin
            $display("%s: processor never reached halt within %0d cycles", testName, limit);
            errorCount++;
        end
    endtask

    task automatic stopCpu();
        waitDriveSlot();
        run = 1'b0;
        waitDriveSlot(); // one edge in stopped
    endtask

    task automatic compareOutputs();
        int seenCount;
        seenCount = seenOut.size() - outBase;
        checkValue("outValid pulses", 32'(expectedOut.size()), 32'(seenCount));
        foreach (expectedOut[i]) begin
            if (i < seenCount) begin
                checkValue($sformatf("outPort[%0d]", i), expectedOut[i], seenOut[outBase + i]);
            end
        end
    endtask

    task automatic beginTest();
        progWords.delete();
        expectedOut.delete();
        errorsAtStart = errorCount;
    endtask

    task automatic finishTest(input string name);
        if (errorCount == errorsAtStart) begin
            testsPassed++;
            $display("test %s: ok", name);
        end else begin
            testsFailed++;
            $display("test %s: FAILED with %0d errors", name, errorCount - errorsAtStart);
        end
    endtask

    task automatic testHostPort();
        logic [31:0] written[16];
        logic [31:0] data;
        beginTest();
        for (int i = 0; i < 16; i++) begin
            written[i] = $urandom();
            writeWord(9'(i * 31 + 7), written[i]); // spread over the array
        end
        releaseHost();
        for (int i = 0; i < 16; i++) begin
            readWord(9'(i * 31 + 7), data);
            checkValue($sformatf("mem[%0d]", i * 31 + 7), written[i], data);
        end
        finishTest("host port");
    endtask

    task automatic testAluOps();
        logic [18:0] k1, k2, k3;
        logic [31:0] r1, r2, imm;
        beginTest();
        k1  = 19'($urandom());
        k2  = 19'($urandom());
        k3  = 19'($urandom());
        r1  = signExtend19(k1);
        r2  = signExtend19(k2);
        imm = signExtend19(k3);
        progWords.push_back(encodeImm(codeLdi, 4'd1, 4'd0, k1));
        progWords.push_back(encodeImm(codeLdi, 4'd2, 4'd0, k2));
        progWords.push_back(encodeReg(codeAdd, 4'd4, 4'd1, 4'd2));
        progWords.push_back(encodeOut(4'd4));
        progWords.push_back(encodeReg(codeSub, 4'd5, 4'd1, 4'd2));
        progWords.push_back(encodeOut(4'd5));
        progWords.push_back(encodeReg(codeAnd, 4'd6, 4'd1, 4'd2));
        progWords.push_back(encodeOut(4'd6));
        progWords.push_back(encodeReg(codeOr, 4'd7, 4'd1, 4'd2));
        progWords.push_back(encodeOut(4'd7));
        progWords.push_back(encodeImm(codeAddi, 4'd8, 4'd1, k3));
        progWords.push_back(encodeOut(4'd8));
        progWords.push_back(encodeImm(codeAndi, 4'd9, 4'd2, k3));
        progWords.push_back(encodeOut(4'd9));
        progWords.push_back(encodeImm(codeOri, 4'd10, 4'd1, k3));
        progWords.push_back(encodeOut(4'd10));
        progWords.push_back(encodeOut(4'd1));
        progWords.push_back(encodeOut(4'd2));
        progWords.push_back(encodeImm(codeHalt, 4'd0, 4'd0, 19'd0));
        expectedOut = '{r1 + r2, r1 - r2, r1 & r2, r1 | r2, r1 + imm, r2 & imm, r1 | imm, r1, r2};
        loadProgram();
        runUntilHalt("alu ops");
        stopCpu();
        compareOutputs();
        finishTest("alu ops");
    endtask

    task automatic testLoadStore();
        logic [31:0] valA, valB, data;
        logic [31:0] base;
        logic [8:0]  addr;
        beginTest();
        valA = $urandom();
        valB = $urandom();
        base = 32'd296; // ldi into r2
        progWords.push_back(encodeImm(codeLdi, 4'd0, 4'd0, 19'd37)); // nonzero r0 that rb 0 ignores
        progWords.push_back(encodeImm(codeLd, 4'd1, 4'd0, 19'd300));
        progWords.push_back(encodeImm(codeLdi, 4'd2, 4'd0, 19'd296));
        progWords.push_back(encodeImm(codeLd, 4'd3, 4'd2, 19'd5));
        progWords.push_back(encodeReg(codeAdd, 4'd4, 4'd1, 4'd3));
        progWords.push_back(encodeImm(codeSt, 4'd4, 4'd0, 19'd310));
        progWords.push_back(encodeImm(codeSt, 4'd1, 4'd2, 19'd20));
        progWords.push_back(encodeImm(codeLdi, 4'd5, 4'd2, 19'd4));
        progWords.push_back(encodeImm(codeSt, 4'd3, 4'd5, 19'd12));
        progWords.push_back(encodeImm(codeLd, 4'd6, 4'd0, 19'd310)); // reads back the st
        progWords.push_back(encodeImm(codeSt, 4'd1, 4'd0, 19'd832)); // wraps past the top
        progWords.push_back(encodeOut(4'd1));
        progWords.push_back(encodeOut(4'd3));
        progWords.push_back(encodeOut(4'd5));
        progWords.push_back(encodeOut(4'd6));
        progWords.push_back(encodeImm(codeHalt, 4'd0, 4'd0, 19'd0));
        expectedOut = '{valA, valB, base + 32'd4, valA + valB};
        loadProgram();
        writeWord(effectiveAddress(32'd0, 19'd300), valA);
        writeWord(effectiveAddress(base, 19'd5), valB);
        releaseHost();
        runUntilHalt("load store");
        stopCpu();
        compareOutputs();
        addr = effectiveAddress(32'd0, 19'd310);
        readWord(addr, data);
        checkValue($sformatf("mem[%0d]", addr), valA + valB, data);
        addr = effectiveAddress(base, 19'd20);
        readWord(addr, data);
        checkValue($sformatf("mem[%0d]", addr), valA, data);
        addr = effectiveAddress(base + 32'd4, 19'd12);
        readWord(addr, data);
        checkValue($sformatf("mem[%0d]", addr), valB, data);
        addr = effectiveAddress(32'd0, 19'd832);
        readWord(addr, data);
        checkValue($sformatf("mem[%0d]", addr), valA, data);
        finishTest("load store");
    endtask

    task automatic testBranches();
        logic [18:0] posK, negK, ntMarker, tMarker;
        logic [31:0] regVal[4];
        logic [3:0]  caseReg[8];
        logic [1:0]  caseCond[8];
        logic [1:0]  cond;
        beginTest();
        posK     = {1'b0, 18'($urandom())} | 19'd1; // nonzero with sign clear
        negK     = {1'b1, 18'($urandom())};
        regVal   = '{32'd0, 32'd0, signExtend19(posK), signExtend19(negK)};
        caseReg  = '{4'd1, 4'd2, 4'd2, 4'd1, 4'd2, 4'd3, 4'd3, 4'd2};
        caseCond = '{2'd0, 2'd0, 2'd1, 2'd1, 2'd2, 2'd2, 2'd3, 2'd3};
        progWords.push_back(encodeImm(codeLdi, 4'd1, 4'd0, 19'd0));
        progWords.push_back(encodeImm(codeLdi, 4'd2, 4'd0, posK));
        progWords.push_back(encodeImm(codeLdi, 4'd3, 4'd0, negK));
        for (int c = 0; c < 8; c++) begin
            cond     = caseCond[c];
            ntMarker = 19'(32'h100 + 2 * c);
            tMarker  = 19'(32'h101 + 2 * c);
            // offset 4+cond also carries cond in its low bits
            progWords.push_back(encodeImm(codeBr, caseReg[c], 4'd0, 19'(4 + cond)));
            progWords.push_back(encodeImm(codeLdi, 4'd9, 4'd0, ntMarker));
            progWords.push_back(encodeOut(4'd9));
            progWords.push_back(encodeImm(codeBr, 4'd1, 4'd0, 19'd8)); // always taken on r1 zero
            for (int n = 0; n <= int'(cond); n++) begin
                progWords.push_back(encodeImm(codeNop, 4'd0, 4'd0, 19'd0));
            end
            progWords.push_back(encodeImm(codeLdi, 4'd9, 4'd0, tMarker)); // taken target
            progWords.push_back(encodeOut(4'd9));
            for (int n = int'(cond); n < 5; n++) begin
                progWords.push_back(encodeImm(codeNop, 4'd0, 4'd0, 19'd0));
            end
            if (branchTaken(regVal[caseReg[c]], cond)) begin
                expectedOut.push_back(signExtend19(tMarker));
            end else begin
                expectedOut.push_back(signExtend19(ntMarker));
            end
        end
        progWords.push_back(encodeImm(codeHalt, 4'd0, 4'd0, 19'd0));
        loadProgram();
        runUntilHalt("branches");
        stopCpu();
        compareOutputs();
        finishTest("branches");
    endtask

    task automatic testJumpsAndIo();
        logic [31:0] inValue;
        logic [31:0] jalAddr;
        beginTest();
        inValue = $urandom();
        progWords.push_back(encodeImm(codeLdi, 4'd1, 4'd0, 19'd10)); // subroutine address
        jalAddr = 32'(progWords.size());
        progWords.push_back(encodeImm(codeJal, 4'd1, 4'd0, 19'd0));
        progWords.push_back(encodeImm(codeIn, 4'd3, 4'd0, 19'd0));
        progWords.push_back(encodeOut(4'd3));
        progWords.push_back(encodeImm(codeHalt, 4'd0, 4'd0, 19'd0));
        while (progWords.size() < 10) begin
            progWords.push_back(encodeImm(codeNop, 4'd0, 4'd0, 19'd0));
        end
        progWords.push_back(encodeOut(4'd15)); // link register
        progWords.push_back(encodeImm(codeJr, 4'd15, 4'd0, 19'd0));
        expectedOut = '{jalAddr + 32'd1, inValue};
        loadProgram();
        waitDriveSlot();
        inPort = inValue;
        runUntilHalt("jumps and io");
        stopCpu();
        checkValue("halted", 32'd0, {31'd0, halted}); // cleared by run low
        compareOutputs();
        // second program starts again at address 0
        progWords.delete();
        expectedOut.delete();
        progWords.push_back(encodeImm(codeLdi, 4'd4, 4'd0, 19'h5a5));
        progWords.push_back(encodeOut(4'd4));
        progWords.push_back(encodeImm(codeHalt, 4'd0, 4'd0, 19'd0));
        expectedOut.push_back(signExtend19(19'h5a5));
        loadProgram();
        runUntilHalt("jumps and io restart");
        stopCpu();
        compareOutputs();
        finishTest("jumps and io");
    endtask

    initial begin
        run         = 1'b0;
        hostReq     = '0;
        inPort      = '0;
        errorCount  = 0;
        testsPassed = 0;
        testsFailed = 0;
        outBase     = 0;
        void'($urandom(32'hd4a8_2e14));
        @(posedge arstN);
        testHostPort();
        testAluOps();
        testLoadStore();
        testBranches();
        testJumpsAndIo();
        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 testsPassed, testsFailed, errorCount);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("timeout: tests still running after %0d ns", watchdogNs);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "srcCpu_config.svh"

module alu import srcCpuPkg::*; (
    input  aluOpT              aluOp,
    input  logic [`WORD_W-1:0] a,
    input  logic [`WORD_W-1:0] b,
    input  logic [1:0]         cond,      // c2[1:0] of br
    input  logic [`WORD_W-1:0] condValue, // R[ra]
    output logic [`WORD_W-1:0] result,
    output logic               condTrue
);

    always_comb begin
        case (aluOp)
            aluAdd:   result = a + b; // also effective address
            aluSub:   result = a - b;
            aluAnd:   result = a & b;
            aluOr:    result = a | b;
            aluPassB: result = b;
            default:  result = b;
        endcase
    end

    // branch test
    always_comb begin
        case (cond)
            2'd0:    condTrue = (condValue == '0);    // zero
            2'd1:    condTrue = (condValue != '0);    // nonzero
            2'd2:    condTrue = !condValue[`WORD_W-1]; // positive, zero counts
            default: condTrue = condValue[`WORD_W-1];  // negative
        endcase
    end

endmodule

`default_nettype wire

/* verilog/controlUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module controlUnit import srcCpuPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    input  logic   run,
    input  decodeT decode,
    output ctrlT   ctrl,
    output logic   pcClear,
    output logic   hostOwns,
    output logic   halted
);

    cpuStateT state, stateNext;

    assign hostOwns = !run;                            // memory goes to host
    assign pcClear  = !run || (state == stStopped);    // pc sits at 0 while parked
    assign halted   = (state == stHalted);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state <= stStopped;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = state;
        if (!run) begin
            stateNext = stStopped; // from any state
        end else begin
            case (state)
                stStopped:   stateNext = stFetch;
                stFetch:     stateNext = stIrLoad;
                stIrLoad:    stateNext = stExecute;
                stExecute: begin
                    if (decode.opcode == opLd) begin
                        stateNext = stLoadWrite; // one extra cycle
                    end else if (decode.opcode == opHalt) begin
                        stateNext = stHalted;
                    end else begin
                        stateNext = stFetch;
                    end
                end
                stLoadWrite: stateNext = stFetch;
                stHalted:    stateNext = stHalted; // wait for run low
                default:     stateNext = stStopped;
            endcase
        end
    end

    // control word per state
    always_comb begin
        ctrl        = '0;
        ctrl.useImm = 1'b1;     // port A on ra by default
        ctrl.aluOp  = aluPassB;
        ctrl.wbSel  = wbAlu;
        if (run) begin
            case (state)
                stFetch: begin
                    ctrl.memRead    = 1'b1;
                    ctrl.addrFromPc = 1'b1;
                end
                stIrLoad: ctrl.irLoad = 1'b1;
                stExecute: begin
                    case (decode.opcode)
                        opLd: begin
                            ctrl.aluOp   = aluAdd; // ea
                            ctrl.memRead = 1'b1;
                            ctrl.pcInc   = 1'b1;
                        end
                        opLdi: begin
                            ctrl.aluOp    = aluAdd;
                            ctrl.regWrite = 1'b1;
                            ctrl.pcInc    = 1'b1;
                        end
                        opSt: begin
                            ctrl.aluOp    = aluAdd;
                            ctrl.memWrite = 1'b1; // data from R[ra]
                            ctrl.pcInc    = 1'b1;
                        end
                        opAdd, opSub, opAnd, opOr: begin
                            ctrl.useImm   = 1'b0; // b from R[rc]
                            ctrl.aluOp    = (decode.opcode == opAdd) ? aluAdd :
                                            (decode.opcode == opSub) ? aluSub :
                                            (decode.opcode == opAnd) ? aluAnd : aluOr;
                            ctrl.regWrite = 1'b1;
                            ctrl.pcInc    = 1'b1;
                        end
                        opAddi, opAndi, opOri: begin
                            ctrl.aluOp    = (decode.opcode == opAddi) ? aluAdd :
                                            (decode.opcode == opAndi) ? aluAnd : aluOr;
                            ctrl.regWrite = 1'b1;
                            ctrl.pcInc    = 1'b1;
                        end
                        opBr: begin
                            ctrl.pcBranch = decode.condTrue;
                            ctrl.pcInc    = !decode.condTrue; // fall through
                        end
                        opJr: ctrl.pcJump = 1'b1;
                        opJal: begin
                            ctrl.pcJump   = 1'b1;
                            ctrl.regWrite = 1'b1;
                            ctrl.wbSel    = wbLink; // R15 <= pc + 1
                        end
                        opIn: begin
                            ctrl.regWrite = 1'b1;
                            ctrl.wbSel    = wbInPort;
                            ctrl.pcInc    = 1'b1;
                        end
                        opOut: begin
                            ctrl.outStrobe = 1'b1;
                            ctrl.pcInc     = 1'b1;
                        end
                        opHalt: ctrl.pcInc = 1'b0; // pc stays on halt
                        default: ctrl.pcInc = 1'b1; // nop and unknown codes
                    endcase
                end
                stLoadWrite: begin
                    ctrl.regWrite = 1'b1;
                    ctrl.wbSel    = wbMemory;
                end
                default: ctrl.pcInc = 1'b0; // stopped and halted do nothing
            endcase
        end
    end

endmodule

`default_nettype wire

/* verilog/datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "srcCpu_config.svh"

module datapath import srcCpuPkg::*; (
    input  logic               clk,
    input  logic               arstN,
    input  ctrlT               ctrl,
    output decodeT             decode,
    output memReqT             memReq,
    input  logic [`WORD_W-1:0] memRdata,
    input  logic [`WORD_W-1:0] inPort,
    output logic [`WORD_W-1:0] outPort,
    output logic               outValid,
    input  logic               pcClear
);

    localparam int addrW = `MEM_ADDR_W;

    logic [addrW-1:0]       pc;
    logic [addrW-1:0]       pcPlusOne;
    logic [`WORD_W-1:0]     ir;
    opcodeT                 irOpcode;
    logic [`REG_ADDR_W-1:0] ra, rb, rc;
    logic [`WORD_W-1:0]     c2;        // sign-extended constant
    logic                   isAddrOp;  // ld, ldi, st treat rb 0 as zero
    logic [`REG_ADDR_W-1:0] readAddrA;
    logic [`WORD_W-1:0]     readDataA, readDataB;
    logic [`WORD_W-1:0]     aOperand, bOperand;
    logic [`WORD_W-1:0]     aluResult;
    logic                   condTrue;
    logic [`REG_ADDR_W-1:0] writeAddr;
    logic [`WORD_W-1:0]     writeData;

    // instruction fields
    assign irOpcode = opcodeT'(ir[31:27]);
    assign ra       = ir[26:23];
    assign rb       = ir[22:19];
    assign rc       = ir[18:15];
    assign c2       = {{(`WORD_W-19){ir[18]}}, ir[18:0]};
    assign isAddrOp = (irOpcode == opLd) || (irOpcode == opLdi) || (irOpcode == opSt);

    assign pcPlusOne = pc + addrW'(1);

    // port A gives rc for reg-reg ops, ra for everything else
    assign readAddrA = ctrl.useImm ? ra : rc;

    registerFile u_registerFile (
        .clk       (clk),
        .arstN     (arstN),
        .readAddrA (readAddrA),
        .readAddrB (rb),
        .readDataA (readDataA),
        .readDataB (readDataB),
        .writeEn   (ctrl.regWrite),
        .writeAddr (writeAddr),
        .writeData (writeData)
    );

    assign aOperand = (isAddrOp && rb == '0) ? '0 : readDataB; // base register
    assign bOperand = ctrl.useImm ? c2 : readDataA;

    alu u_alu (
        .aluOp     (ctrl.aluOp),
        .a         (aOperand),
        .b         (bOperand),
        .cond      (ir[1:0]),
        .condValue (readDataA), // R[ra] since useImm is set for br
        .result    (aluResult),
        .condTrue  (condTrue)
    );

    assign decode.opcode   = irOpcode;
    assign decode.condTrue = condTrue;

    // memory request, st data comes from R[ra]
    assign memReq.read  = ctrl.memRead;
    assign memReq.write = ctrl.memWrite;
    assign memReq.addr  = ctrl.addrFromPc ? pc : aluResult[addrW-1:0]; // truncated ea
    assign memReq.wdata = readDataA;

    // write-back
    assign writeAddr = (ctrl.wbSel == wbLink) ? `REG_ADDR_W'(`LINK_REG) : ra;

    always_comb begin
        case (ctrl.wbSel)
            wbAlu:    writeData = aluResult;
            wbMemory: writeData = memRdata; // ld word registered by memory
            wbInPort: writeData = inPort;
            default:  writeData = {{(`WORD_W-addrW){1'b0}}, pcPlusOne}; // return address
        endcase
    end

    always_ff @(posedge clk) begin
        if (ctrl.irLoad) begin
            ir <= memRdata; // word fetched last cycle
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (pcClear) begin
            pc <= '0; // run dropped or parked
        end else if (ctrl.pcJump) begin
            pc <= readDataA[addrW-1:0]; // jr and jal
        end else if (ctrl.pcBranch) begin
            pc <= pcPlusOne + c2[addrW-1:0];
        end else if (ctrl.pcInc) begin
            pc <= pcPlusOne;
        end
    end

    // out port, valid for one cycle after the out executes
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outPort  <= '0;
            outValid <= 1'b0;
        end else begin
            outValid <= ctrl.outStrobe;
            if (ctrl.outStrobe) begin
                outPort <= readDataA; // held until next out
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/mainMemory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "srcCpu_config.svh"

module mainMemory import srcCpuPkg::*; (
    input  logic               clk,
    input  memReqT             cpuReq,
    input  memReqT             hostReq,
    input  logic               hostSel, // host wins while cpu is stopped
    output logic [`WORD_W-1:0] rdata
);

    logic [`WORD_W-1:0] mem [`MEM_DEPTH]; // instructions and data together
    memReqT             req;               // request after arbitration

    assign req = hostSel ? hostReq : cpuReq; // cpu request dropped while host owns

    always_ff @(posedge clk) begin
        if (req.write) begin
            mem[req.addr] <= req.wdata; // write lands on the edge
        end
        if (req.read) begin
            rdata <= mem[req.addr]; // data one clock after address
        end
    end

endmodule

`default_nettype wire

/* verilog/registerFile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "srcCpu_config.svh"

module registerFile (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [`REG_ADDR_W-1:0] readAddrA,
    input  logic [`REG_ADDR_W-1:0] readAddrB,
    output logic [`WORD_W-1:0]     readDataA,
    output logic [`WORD_W-1:0]     readDataB,
    input  logic                   writeEn,
    input  logic [`REG_ADDR_W-1:0] writeAddr,
    input  logic [`WORD_W-1:0]     writeData
);

    logic [`WORD_W-1:0] regs [`REG_COUNT];

    // combinational reads, a write shows up next cycle
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0; // all registers start at zero
            end
        end else if (writeEn) begin
            regs[writeAddr] <= writeData;
        end
    end

endmodule

`default_nettype wire

/* verilog/srcCpu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "srcCpu_config.svh"

module srcCpu import srcCpuPkg::*; (
    input  logic               clk,
    input  logic               arstN,
    input  logic               run,
    input  memReqT             hostReq,
    output logic [`WORD_W-1:0] hostRdata,
    input  logic [`WORD_W-1:0] inPort,
    output logic [`WORD_W-1:0] outPort,
    output logic               outValid,
    output logic               halted
);

    ctrlT               ctrl;
    decodeT             decode;
    memReqT             cpuReq;
    logic [`WORD_W-1:0] memRdata;
    logic               pcClear;
    logic               hostOwns;

    assign hostRdata = memRdata; // valid the cycle after a host read

    controlUnit u_controlUnit (
        .clk      (clk),
        .arstN    (arstN),
        .run      (run),
        .decode   (decode),
        .ctrl     (ctrl),
        .pcClear  (pcClear),
        .hostOwns (hostOwns),
        .halted   (halted)
    );

    datapath u_datapath (
        .clk      (clk),
        .arstN    (arstN),
        .ctrl     (ctrl),
        .decode   (decode),
        .memReq   (cpuReq),
        .memRdata (memRdata),
        .inPort   (inPort),
        .outPort  (outPort),
        .outValid (outValid),
        .pcClear  (pcClear)
    );

    mainMemory u_mainMemory (
        .clk     (clk),
        .cpuReq  (cpuReq),
        .hostReq (hostReq),
        .hostSel (hostOwns),
        .rdata   (memRdata)
    );

endmodule

`default_nettype wire

/* verilog/srcCpuPkg.sv */
`default_nettype none

`include "srcCpu_config.svh"

package srcCpuPkg;

    // kept SRC opcodes, numbering matches the instruction set
    typedef enum logic [4:0] {
        opLd   = 5'd0,
        opLdi  = 5'd1,
        opSt   = 5'd2,
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opAnd  = 5'd5,
        opOr   = 5'd6,
        opAddi = 5'd12,
        opAndi = 5'd13,
        opOri  = 5'd14,
        opBr   = 5'd19,
        opJr   = 5'd20,
        opJal  = 5'd21,
        opIn   = 5'd22,
        opOut  = 5'd23,
        opNop  = 5'd26,
        opHalt = 5'd27
    } opcodeT;

    typedef enum logic [2:0] {
        stStopped,   // host owns memory
        stFetch,     // read at pc
        stIrLoad,    // ir captures word
        stExecute,
        stLoadWrite, // ld data back to ra
        stHalted
    } cpuStateT;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluPassB} aluOpT;

    typedef enum logic [1:0] {wbAlu, wbMemory, wbInPort, wbLink} wbSelT;

    typedef struct packed {
        logic  pcInc;      // pc <= pc + 1
        logic  pcBranch;   // pc <= pc + 1 + c2
        logic  pcJump;     // pc <= R[ra]
        logic  irLoad;
        logic  regWrite;
        wbSelT wbSel;
        aluOpT aluOp;
        logic  useImm;     // b operand is c2, port A reads ra
        logic  memRead;
        logic  memWrite;
        logic  addrFromPc; // fetch address
        logic  outStrobe;
    } ctrlT;

    typedef struct packed {
        opcodeT opcode;
        logic   condTrue; // branch test on R[ra]
    } decodeT;

    typedef struct packed {
        logic                   read;
        logic                   write;
        logic [`MEM_ADDR_W-1:0] addr;
        logic [`WORD_W-1:0]     wdata;
    } memReqT;

endpackage

`default_nettype wire

/* verilog/srcCpu_config.svh */
`ifndef SRC_CPU_CONFIG_SVH
`define SRC_CPU_CONFIG_SVH

// sizes shared by the memory, datapath and register file

`define MEM_DEPTH   512 // words of unified memory
`define MEM_ADDR_W  9   // word address bits
`define WORD_W      32  // data word width

`define REG_COUNT   16  // general registers
`define REG_ADDR_W  4   // register index bits
`define LINK_REG    15  // jal return address lands here

`endif
